/* verilog/fsctl_pkg.sv */
`default_nettype none

package fsctl_pkg;

	// --------------------------------------------------
	// widths and limits
	// --------------------------------------------------
	localparam int IMG_WBITS     = 12;
	localparam int IMG_HBITS     = 12;
	localparam int DATA_WIDTH    = 32;
	localparam int REG_IDX_WIDTH = 8;
	localparam int BUF_IDX_WIDTH = 2;
	localparam int MAX_STREAMS   = 8;

	localparam logic [DATA_WIDTH-1:0] CORE_VERSION = 32'hFF00FF00;

	// --------------------------------------------------
	// register map
	// --------------------------------------------------
	localparam logic [REG_IDX_WIDTH-1:0] REG_INT_EN     = 8'd0;
	localparam logic [REG_IDX_WIDTH-1:0] REG_INT_STATE  = 8'd1;
	localparam logic [REG_IDX_WIDTH-1:0] REG_BUF_IDX    = 8'd2;
	localparam logic [REG_IDX_WIDTH-1:0] REG_CFG_LOCK   = 8'd3;
	localparam logic [REG_IDX_WIDTH-1:0] REG_OP_EN      = 8'd4;
	// staging set, 5 to 11
	localparam logic [REG_IDX_WIDTH-1:0] REG_SOFT_RST   = 8'd5;
	localparam logic [REG_IDX_WIDTH-1:0] REG_DST_BMP    = 8'd6;
	localparam logic [REG_IDX_WIDTH-1:0] REG_SIZE       = 8'd7;
	localparam logic [REG_IDX_WIDTH-1:0] REG_WIN_POS    = 8'd8;
	localparam logic [REG_IDX_WIDTH-1:0] REG_WIN_SIZE   = 8'd9;
	localparam logic [REG_IDX_WIDTH-1:0] REG_DST_POS    = 8'd10;
	localparam logic [REG_IDX_WIDTH-1:0] REG_DST_SIZE   = 8'd11;
	localparam logic [REG_IDX_WIDTH-1:0] REG_GLOBAL_RST = 8'd254;
	localparam logic [REG_IDX_WIDTH-1:0] REG_VERSION    = 8'd255;

	// width or left in the upper half, height or top in the lower half
	typedef struct packed {
		logic [DATA_WIDTH/2-IMG_WBITS-1:0] rsv_hi;
		logic [IMG_WBITS-1:0]              width;
		logic [DATA_WIDTH/2-IMG_HBITS-1:0] rsv_lo;
		logic [IMG_HBITS-1:0]              height;
	} dim_pair_t;

	typedef union packed {
		logic [DATA_WIDTH-1:0] raw;
		dim_pair_t             dim;
	} reg_word_u;

	typedef struct packed {
		logic                     en;
		logic [REG_IDX_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0]    data;
	} reg_wr_t;

	typedef struct packed {
		logic                   soft_resetn;
		logic [MAX_STREAMS-1:0] dst_bmp;
		logic [IMG_WBITS-1:0]   width;
		logic [IMG_HBITS-1:0]   height;
		logic [IMG_WBITS-1:0]   win_left;
		logic [IMG_HBITS-1:0]   win_top;
		logic [IMG_WBITS-1:0]   win_width;
		logic [IMG_HBITS-1:0]   win_height;
		logic [IMG_WBITS-1:0]   dst_left;
		logic [IMG_HBITS-1:0]   dst_top;
		logic [IMG_WBITS-1:0]   dst_width;
		logic [IMG_HBITS-1:0]   dst_height;
	} stream_cfg_t;

endpackage

`default_nettype wire

/* verilog/cfg_regs.sv */
`default_nettype none

module cfg_regs
	import fsctl_pkg::*;
#(
	parameter int STREAM_NBR = 2
) (
	input  wire logic              o_clk,
	input  wire logic              o_resetn,
	input  reg_wr_t                i_wr,
	output stream_cfg_t            o_staging,
	output logic [STREAM_NBR-1:0]  o_op_en,
	output logic                   o_cfg_lock,
	output logic                   o_soft_resetn
);

	// only the streams that exist may be named as destinations
	localparam logic [MAX_STREAMS-1:0] STREAM_MASK = MAX_STREAMS'((1 << STREAM_NBR) - 1);

	reg_word_u wr_word;

	assign wr_word.raw = i_wr.data;

	// --------------------------------------------------
	// control bits
	// --------------------------------------------------
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_op_en       <= '0;
			o_cfg_lock    <= 1'b0;
			o_soft_resetn <= 1'b0;
		end else if (i_wr.en) begin
			case (i_wr.addr)
				REG_CFG_LOCK:   o_cfg_lock    <= wr_word.raw[0];
				REG_OP_EN:      o_op_en       <= wr_word.raw[STREAM_NBR-1:0];
				REG_GLOBAL_RST: o_soft_resetn <= wr_word.raw[0];
				default: ;
			endcase
		end
	end

	// --------------------------------------------------
	// staging set, shared by all streams
	// --------------------------------------------------
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_staging <= '0;
		end else if (i_wr.en) begin
			case (i_wr.addr)
				REG_SOFT_RST: begin
					o_staging.soft_resetn <= wr_word.raw[0];
				end
				REG_DST_BMP: begin
					o_staging.dst_bmp <= wr_word.raw[MAX_STREAMS-1:0] & STREAM_MASK;
				end
				REG_SIZE: begin
					o_staging.width  <= wr_word.dim.width;
					o_staging.height <= wr_word.dim.height;
				end
				// position words carry left and top in the size slots
				REG_WIN_POS: begin
					o_staging.win_left <= wr_word.dim.width;
					o_staging.win_top  <= wr_word.dim.height;
				end
				REG_WIN_SIZE: begin
					o_staging.win_width  <= wr_word.dim.width;
					o_staging.win_height <= wr_word.dim.height;
				end
				REG_DST_POS: begin
					o_staging.dst_left <= wr_word.dim.width;
					o_staging.dst_top  <= wr_word.dim.height;
				end
				REG_DST_SIZE: begin
					o_staging.dst_width  <= wr_word.dim.width;
					o_staging.dst_height <= wr_word.dim.height;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/frame_sync.sv */
`default_nettype none

module frame_sync #(
	parameter int STREAM_NBR = 2
) (
	input  wire logic  o_clk,
	input  wire logic  o_resetn,
	input  wire logic  i_fsync,
	input  wire logic  i_cfg_lock,
	output logic       o_update,
	output logic       o_fsync,
	output logic       o_out_ce
);

	logic fsync_d1;
	logic fsync_d2;
	logic fsync_edge;

	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			fsync_d1   <= 1'b0;
			fsync_d2   <= 1'b0;
			fsync_edge <= 1'b0;
		end else begin
			fsync_d1   <= i_fsync;
			fsync_d2   <= fsync_d1;
			fsync_edge <= fsync_d1 & ~fsync_d2;
		end
	end

	// shadow copy lands on the same edge that raises o_fsync
	assign o_update = fsync_edge & ~i_cfg_lock;

	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_fsync  <= 1'b0;
			o_out_ce <= 1'b0;
		end else begin
			o_fsync <= fsync_edge;
			if (o_fsync)
				o_out_ce <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* verilog/stream_shadow.sv */
`default_nettype none

module stream_shadow
	import fsctl_pkg::*;
#(
	parameter int STREAM_NBR = 2
) (
	input  wire logic                   o_clk,
	input  wire logic                   o_resetn,
	input  wire logic                   i_update,
	input  wire logic [STREAM_NBR-1:0]  i_op_en,
	input  stream_cfg_t                 i_staging,
	output stream_cfg_t                 o_stream_cfg [STREAM_NBR]
);

	// --------------------------------------------------
	// active configuration, one per stream
	// --------------------------------------------------
	stream_cfg_t active_cfg [STREAM_NBR];
	logic [STREAM_NBR-1:0] load;

	// a stream takes the staging set only when selected at the frame edge
	assign load = i_update ? i_op_en : '0;

	for (genvar k = 0; k < STREAM_NBR; k++) begin : g_stream
		always_ff @(posedge o_clk) begin
			if (!o_resetn)
				active_cfg[k] <= '0;
			else if (load[k])
				active_cfg[k] <= i_staging;
		end

		assign o_stream_cfg[k] = active_cfg[k];
	end

endmodule

`default_nettype wire

/* verilog/intr_ctrl.sv */
`default_nettype none

module intr_ctrl
	import fsctl_pkg::*;
#(
	parameter int STREAM_NBR = 2
) (
	input  wire logic                   o_clk,
	input  wire logic                   o_resetn,
	input  reg_wr_t                     i_wr,
	input  wire logic [STREAM_NBR-1:0]  i_wr_done,
	output logic [STREAM_NBR-1:0]       o_int_en,
	output logic [STREAM_NBR-1:0]       o_int_state,
	output logic [STREAM_NBR-1:0]       o_rd_req,
	output logic                        o_intr
);

	logic [STREAM_NBR-1:0] wr_done_d;
	logic [STREAM_NBR-1:0] done_rise;
	logic [STREAM_NBR-1:0] state_clr;
	logic                  en_wr;
	logic                  state_wr;

	assign en_wr    = i_wr.en && (i_wr.addr == REG_INT_EN);
	assign state_wr = i_wr.en && (i_wr.addr == REG_INT_STATE);

	assign done_rise = i_wr_done & ~wr_done_d;
	// write one to clear
	assign state_clr = state_wr ? i_wr.data[STREAM_NBR-1:0] : '0;

	// --------------------------------------------------
	// enable, state and read requests
	// --------------------------------------------------
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			wr_done_d   <= '0;
			o_int_en    <= '0;
			o_int_state <= '0;
			o_rd_req    <= '0;
		end else begin
			wr_done_d <= i_wr_done;
			if (en_wr)
				o_int_en <= i_wr.data[STREAM_NBR-1:0];
			// a new edge beats a clear in the same cycle
			o_int_state <= (o_int_state & ~state_clr) | done_rise;
			o_rd_req    <= state_clr;
		end
	end

	assign o_intr = |(o_int_en & o_int_state);

endmodule

`default_nettype wire

/* verilog/reg_read_mux.sv */
`default_nettype none

module reg_read_mux
	import fsctl_pkg::*;
#(
	parameter int STREAM_NBR = 2
) (
	input  wire logic                                      o_clk,
	input  wire logic                                      i_rd_en,
	input  wire logic [REG_IDX_WIDTH-1:0]                  i_rd_addr,
	input  stream_cfg_t                                    i_staging,
	input  wire logic [STREAM_NBR-1:0]                     i_op_en,
	input  wire logic                                      i_cfg_lock,
	input  wire logic                                      i_soft_resetn,
	input  wire logic [STREAM_NBR-1:0]                     i_int_en,
	input  wire logic [STREAM_NBR-1:0]                     i_int_state,
	input  wire logic [STREAM_NBR-1:0][BUF_IDX_WIDTH-1:0]  i_rd_buf_idx,
	output logic [DATA_WIDTH-1:0]                          o_rd_data
);

	reg_word_u rd_word;

	// --------------------------------------------------
	// word select, unused bits read as zero
	// --------------------------------------------------
	always_comb begin
		rd_word.raw = '0;
		case (i_rd_addr)
			REG_INT_EN:     rd_word.raw[STREAM_NBR-1:0] = i_int_en;
			REG_INT_STATE:  rd_word.raw[STREAM_NBR-1:0] = i_int_state;
			REG_BUF_IDX: begin
				// one nibble per stream
				for (int k = 0; k < STREAM_NBR; k++)
					rd_word.raw[4*k +: BUF_IDX_WIDTH] = i_rd_buf_idx[k];
			end
			REG_CFG_LOCK:   rd_word.raw[0] = i_cfg_lock;
			REG_OP_EN:      rd_word.raw[STREAM_NBR-1:0] = i_op_en;
			REG_SOFT_RST:   rd_word.raw[0] = i_staging.soft_resetn;
			REG_DST_BMP:    rd_word.raw[MAX_STREAMS-1:0] = i_staging.dst_bmp;
			REG_SIZE: begin
				rd_word.dim.width  = i_staging.width;
				rd_word.dim.height = i_staging.height;
			end
			REG_WIN_POS: begin
				rd_word.dim.width  = i_staging.win_left;
				rd_word.dim.height = i_staging.win_top;
			end
			REG_WIN_SIZE: begin
				rd_word.dim.width  = i_staging.win_width;
				rd_word.dim.height = i_staging.win_height;
			end
			REG_DST_POS: begin
				rd_word.dim.width  = i_staging.dst_left;
				rd_word.dim.height = i_staging.dst_top;
			end
			REG_DST_SIZE: begin
				rd_word.dim.width  = i_staging.dst_width;
				rd_word.dim.height = i_staging.dst_height;
			end
			REG_GLOBAL_RST: rd_word.raw[0] = i_soft_resetn;
			REG_VERSION:    rd_word.raw = CORE_VERSION;
			default: ;
		endcase
	end

	// held until the next read
	always_ff @(posedge o_clk) begin
		if (i_rd_en)
			o_rd_data <= rd_word.raw;
	end

endmodule

`default_nettype wire

/* verilog/fsctl_top.sv */
`default_nettype none

module fsctl_top
	import fsctl_pkg::*;
#(
	parameter int STREAM_NBR = 2
) (
	input  wire logic                                      o_clk,
	input  wire logic                                      o_resetn,

	// host register access
	input  reg_wr_t                                        i_wr,
	input  wire logic                                      i_rd_en,
	input  wire logic [REG_IDX_WIDTH-1:0]                  i_rd_addr,
	output logic [DATA_WIDTH-1:0]                          o_rd_data,

	// frame timing
	input  wire logic                                      i_fsync,
	output logic                                           o_fsync,
	output logic                                           o_out_ce,
	output logic                                           o_soft_resetn,
	output logic                                           o_intr,

	// per-stream
	input  wire logic [STREAM_NBR-1:0]                     i_wr_done,
	input  wire logic [STREAM_NBR-1:0][BUF_IDX_WIDTH-1:0]  i_rd_buf_idx,
	output logic [STREAM_NBR-1:0]                          o_rd_req,
	output stream_cfg_t                                    o_stream_cfg [STREAM_NBR]
);

	stream_cfg_t             staging;
	logic [STREAM_NBR-1:0]   op_en;
	logic                    cfg_lock;
	logic                    update;
	logic [STREAM_NBR-1:0]   int_en;
	logic [STREAM_NBR-1:0]   int_state;

	cfg_regs #(.STREAM_NBR(STREAM_NBR)) u_cfg_regs (
		.o_clk         (o_clk),
		.o_resetn      (o_resetn),
		.i_wr          (i_wr),
		.o_staging     (staging),
		.o_op_en       (op_en),
		.o_cfg_lock    (cfg_lock),
		.o_soft_resetn (o_soft_resetn)
	);

	frame_sync #(.STREAM_NBR(STREAM_NBR)) u_frame_sync (
		.o_clk      (o_clk),
		.o_resetn   (o_resetn),
		.i_fsync    (i_fsync),
		.i_cfg_lock (cfg_lock),
		.o_update   (update),
		.o_fsync    (o_fsync),
		.o_out_ce   (o_out_ce)
	);

	stream_shadow #(.STREAM_NBR(STREAM_NBR)) u_stream_shadow (
		.o_clk        (o_clk),
		.o_resetn     (o_resetn),
		.i_update     (update),
		.i_op_en      (op_en),
		.i_staging    (staging),
		.o_stream_cfg (o_stream_cfg)
	);

	intr_ctrl #(.STREAM_NBR(STREAM_NBR)) u_intr_ctrl (
		.o_clk       (o_clk),
		.o_resetn    (o_resetn),
		.i_wr        (i_wr),
		.i_wr_done   (i_wr_done),
		.o_int_en    (int_en),
		.o_int_state (int_state),
		.o_rd_req    (o_rd_req),
		.o_intr      (o_intr)
	);

	reg_read_mux #(.STREAM_NBR(STREAM_NBR)) u_reg_read_mux (
		.o_clk         (o_clk),
		.i_rd_en       (i_rd_en),
		.i_rd_addr     (i_rd_addr),
		.i_staging     (staging),
		.i_op_en       (op_en),
		.i_cfg_lock    (cfg_lock),
		.i_soft_resetn (o_soft_resetn),
		.i_int_en      (int_en),
		.i_int_state   (int_state),
		.i_rd_buf_idx  (i_rd_buf_idx),
		.o_rd_data     (o_rd_data)
	);

endmodule

`default_nettype wire

/* tests/tb_clkgen.sv */
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 2
) (
	output logic o_clk,
	output logic o_resetn
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end

	// release on a falling edge
	initial begin
		o_resetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		o_resetn = 1'b1;
	end

endmodule

`default_nettype wire

/* tests/fsctl_tb.sv */
`default_nettype none

module fsctl_tb
	import fsctl_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NBR           = 2;
	localparam int CLK_PERIOD_NS = 20;
	localparam int N_RAND        = 40;
	// about 40 cycles for each write, read or frame sync
	localparam int WATCHDOG_NS   = ((2 * N_RAND + 40) * 40 + 100) * CLK_PERIOD_NS;
	localparam logic [DATA_WIDTH-1:0] DIM_MASK = 32'h0FFF_0FFF;
	localparam logic [DATA_WIDTH-1:0] BMP_MASK = DATA_WIDTH'((1 << NBR) - 1);

	logic                                 clk;
	logic                                 resetn;
	reg_wr_t                              wr;
	logic                                 rd_en;
	logic [REG_IDX_WIDTH-1:0]             rd_addr;
	logic [DATA_WIDTH-1:0]                rd_data;
	logic                                 fsync_in;
	logic                                 fsync_out;
	logic                                 out_ce;
	logic                                 soft_resetn;
	logic                                 intr;
	logic [NBR-1:0]                       wr_done;
	logic [NBR-1:0][BUF_IDX_WIDTH-1:0]    rd_buf_idx;
	logic [NBR-1:0]                       rd_req;
	stream_cfg_t                          stream_cfg [NBR];

	// reference model
	logic [DATA_WIDTH-1:0] stage_word [16];
	logic [NBR-1:0]        model_int_en;
	logic [NBR-1:0]        model_int_state;
	logic [NBR-1:0]        model_op_en;
	logic                  model_lock;
	stream_cfg_t           exp_active [NBR];
	int                    fsync_count;
	int                    seed;

	tb_clkgen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(2)) clkgen0 (
		.o_clk    (clk),
		.o_resetn (resetn)
	);

	fsctl_top #(.STREAM_NBR(NBR)) dut0 (
		.o_clk         (clk),
		.o_resetn      (resetn),
		.i_wr          (wr),
		.i_rd_en       (rd_en),
		.i_rd_addr     (rd_addr),
		.o_rd_data     (rd_data),
		.i_fsync       (fsync_in),
		.o_fsync       (fsync_out),
		.o_out_ce      (out_ce),
		.o_soft_resetn (soft_resetn),
		.o_intr        (intr),
		.i_wr_done     (wr_done),
		.i_rd_buf_idx  (rd_buf_idx),
		.o_rd_req      (rd_req),
		.o_stream_cfg  (stream_cfg)
	);

	// --------------------------------------------------
	// failure handling and compare tasks
	// --------------------------------------------------
	task automatic stop_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] got,
			input logic [DATA_WIDTH-1:0] exp);
		if (got !== exp) begin
			$display("Fail t=%0t %s got=%h exp=%h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_cfg(input string name, input stream_cfg_t got, input stream_cfg_t exp);
		if (got !== exp) begin
			$display("Fail t=%0t %s got=%h exp=%h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail t=%0t %s got=%b exp=%b", $time, name, got, exp);
			stop_run();
		end
	endtask

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	function automatic void model_write(input logic [REG_IDX_WIDTH-1:0] addr,
			input logic [DATA_WIDTH-1:0] data);
		case (addr)
			REG_INT_EN:    model_int_en = data[NBR-1:0];
			REG_INT_STATE: model_int_state = model_int_state & ~data[NBR-1:0];
			REG_CFG_LOCK:  model_lock = data[0];
			REG_OP_EN:     model_op_en = data[NBR-1:0];
			REG_SOFT_RST:  stage_word[5] = data & 32'h1;
			REG_DST_BMP:   stage_word[6] = data & BMP_MASK;
			default: begin
				if (addr >= REG_SIZE && addr <= REG_DST_SIZE)
					stage_word[addr[3:0]] = data & DIM_MASK;
			end
		endcase
	endfunction

	function automatic logic [DATA_WIDTH-1:0] ref_read(input logic [REG_IDX_WIDTH-1:0] addr);
		logic [DATA_WIDTH-1:0] w;
		w = '0;
		case (addr)
			REG_INT_EN:    w[NBR-1:0] = model_int_en;
			REG_INT_STATE: w[NBR-1:0] = model_int_state;
			REG_BUF_IDX: begin
				for (int k = 0; k < NBR; k++)
					w[4*k +: BUF_IDX_WIDTH] = rd_buf_idx[k];
			end
			REG_CFG_LOCK:  w[0] = model_lock;
			REG_OP_EN:     w[NBR-1:0] = model_op_en;
			REG_VERSION:   w = CORE_VERSION;
			default: begin
				if (addr >= REG_SOFT_RST && addr <= REG_DST_SIZE)
					w = stage_word[addr[3:0]];
			end
		endcase
		return w;
	endfunction

	// width or left in 27:16, height or top in 11:0
	function automatic stream_cfg_t ref_cfg();
		stream_cfg_t c;
		c.soft_resetn = stage_word[5][0];
		c.dst_bmp     = stage_word[6][MAX_STREAMS-1:0];
		c.width       = stage_word[7][27:16];
		c.height      = stage_word[7][11:0];
		c.win_left    = stage_word[8][27:16];
		c.win_top     = stage_word[8][11:0];
		c.win_width   = stage_word[9][27:16];
		c.win_height  = stage_word[9][11:0];
		c.dst_left    = stage_word[10][27:16];
		c.dst_top     = stage_word[10][11:0];
		c.dst_width   = stage_word[11][27:16];
		c.dst_height  = stage_word[11][11:0];
		return c;
	endfunction

	// --------------------------------------------------
	// bus tasks
	// --------------------------------------------------
	task automatic write_reg(input logic [REG_IDX_WIDTH-1:0] addr,
			input logic [DATA_WIDTH-1:0] data);
		@(negedge clk);
		wr = '{en: 1'b1, addr: addr, data: data};
		model_write(addr, data);
		@(negedge clk);
		wr.en = 1'b0;
	endtask

	task automatic read_and_check(input logic [REG_IDX_WIDTH-1:0] addr);
		@(negedge clk);
		rd_en   = 1'b1;
		rd_addr = addr;
		@(negedge clk);
		rd_en = 1'b0;
		check_word($sformatf("o_rd_data[reg %0d]", addr), rd_data, ref_read(addr));
	endtask

	task automatic write_staging();
		for (int a = 5; a <= 11; a++)
			write_reg(REG_IDX_WIDTH'(a), $random(seed));
	endtask

	task automatic frame_sync_pulse();
		int start;
		int waited;
		start  = fsync_count;
		waited = 0;
		if (!model_lock) begin
			for (int k = 0; k < NBR; k++)
				if (model_op_en[k])
					exp_active[k] = ref_cfg();
		end
		@(negedge clk);
		fsync_in = 1'b1;
		repeat (3) @(negedge clk);
		fsync_in = 1'b0;
		while (fsync_count == start && waited <= 20) begin
			@(posedge clk);
			waited++;
		end
		if (fsync_count == start) begin
			$display("o_fsync did not follow i_fsync within 20 cycles");
			stop_run();
		end else begin
			@(negedge clk);
		end
	endtask

	// active configuration is compared whenever o_fsync is high
	always @(negedge clk) begin
		if (resetn && fsync_out) begin
			for (int k = 0; k < NBR; k++)
				check_cfg($sformatf("o_stream_cfg[%0d]", k), stream_cfg[k], exp_active[k]);
			fsync_count = fsync_count + 1;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout after %0d ns, the run did not finish", WATCHDOG_NS);
		stop_run();
	end

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	initial begin
		int idx;
		logic [REG_IDX_WIDTH-1:0] addr;
		seed       = 32'h4676665d;
		wr         = '0;
		rd_en      = 1'b0;
		rd_addr    = '0;
		fsync_in   = 1'b0;
		wr_done    = '0;
		rd_buf_idx = '0;
		for (int a = 0; a < 16; a++)
			stage_word[a] = '0;
		model_int_en    = '0;
		model_int_state = '0;
		model_op_en     = '0;
		model_lock      = 1'b0;
		fsync_count     = 0;
		for (int k = 0; k < NBR; k++)
			exp_active[k] = '0;

		wait (resetn === 1'b1);
		@(negedge clk);

		// reset values and version
		check_bit("o_fsync", fsync_out, 1'b0);
		check_bit("o_out_ce", out_ce, 1'b0);
		check_bit("o_intr", intr, 1'b0);
		check_bit("o_soft_resetn", soft_resetn, 1'b0);
		check_bit("o_rd_req[0]", rd_req[0], 1'b0);
		check_bit("o_rd_req[1]", rd_req[1], 1'b0);
		for (int k = 0; k < NBR; k++)
			check_cfg($sformatf("o_stream_cfg[%0d]", k), stream_cfg[k], exp_active[k]);
		read_and_check(REG_VERSION);

		// random register traffic
		for (int n = 0; n < N_RAND; n++) begin
			idx  = int'($unsigned($random(seed)) % 32'd10);
			addr = (idx == 0) ? REG_INT_EN :
				(idx == 1) ? REG_CFG_LOCK :
				(idx == 2) ? REG_OP_EN : REG_IDX_WIDTH'(idx + 2);
			write_reg(addr, $random(seed));
			read_and_check(addr);
		end
		rd_buf_idx = (NBR * BUF_IDX_WIDTH)'($unsigned($random(seed)));
		read_and_check(REG_BUF_IDX);

		// transfer into stream 0 only
		write_reg(REG_CFG_LOCK, 32'h0);
		write_reg(REG_OP_EN, 32'h1);
		write_staging();
		check_bit("o_out_ce", out_ce, 1'b0);
		frame_sync_pulse();
		check_bit("o_out_ce", out_ce, 1'b1);

		// locked frame keeps both streams, then the pending set lands
		write_reg(REG_CFG_LOCK, 32'h1);
		write_reg(REG_OP_EN, 32'h3);
		write_staging();
		frame_sync_pulse();
		write_reg(REG_CFG_LOCK, 32'h0);
		frame_sync_pulse();

		// interrupt from stream 1
		write_reg(REG_INT_EN, 32'h2);
		@(negedge clk);
		wr_done[1] = 1'b1;
		model_int_state[1] = 1'b1;
		@(negedge clk);
		check_bit("o_intr", intr, 1'b1);
		read_and_check(REG_INT_STATE);
		wr_done[1] = 1'b0;
		write_reg(REG_INT_EN, 32'h0);
		check_bit("o_intr", intr, 1'b0);
		write_reg(REG_INT_EN, 32'h2);
		check_bit("o_intr", intr, 1'b1);
		write_reg(REG_INT_STATE, 32'h2);
		check_bit("o_rd_req[1]", rd_req[1], 1'b1);
		check_bit("o_rd_req[0]", rd_req[0], 1'b0);
		check_bit("o_intr", intr, 1'b0);
		@(negedge clk);
		check_bit("o_rd_req[1]", rd_req[1], 1'b0);
		read_and_check(REG_INT_STATE);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
verilog/fsctl_pkg.sv
verilog/cfg_regs.sv
verilog/frame_sync.sv
verilog/stream_shadow.sv
verilog/intr_ctrl.sv
verilog/reg_read_mux.sv
verilog/fsctl_top.sv
tests/tb_clkgen.sv
tests/fsctl_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the fsctl testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module fsctl_tb \
	-f all.f -o fsctl_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "build failed"
	exit 1
fi

./obj_dir/fsctl_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulator exited with status $sim_status"
	exit 1
fi

if grep -qx "ALL TESTS PASSED" "$SIM_LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
